//--- cpu16_core.sv
`timescale 1ns/100ps

module cpu16_core import cpu16_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      run,
	input  word_t     imem_data,
	output word_t     imem_addr,
	output logic      retire,
	output word_t     retire_pc,
	output logic      wb_en,
	output reg_addr_t wb_addr,
	output word_t     wb_value,
	output logic      illegal
);

	logic      hold;
	logic      redirect;
	word_t     redirect_pc;
	word_t     if_pc;
	logic      fetch_valid;
	if_id_t    if_payload;
	if_id_t    id_payload;
	logic      id_valid;
	reg_addr_t rf_raddr_a;
	reg_addr_t rf_raddr_b;
	word_t     rf_rdata_a;
	word_t     rf_rdata_b;
	id_ex_t    id_ex_next;
	id_ex_t    ex_payload;
	logic      ex_valid;
	logic      res_valid;
	logic      res_we;
	reg_addr_t res_addr;
	word_t     res_value;
	word_t     res_pc;
	logic      res_illegal;

	assign hold = ~run;
	assign imem_addr = if_pc;
	assign if_payload = '{pc: if_pc, instr: imem_data};

	// IF stage
	fetch_unit u_fetch (
		.clk(clk),
		.rst_n(rst_n),
		.run(run),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.pc(if_pc),
		.fetch_valid(fetch_valid)
	);

	pipe_reg #(.payload_t(if_id_t)) u_if_id (
		.clk(clk),
		.rst_n(rst_n),
		.hold(hold),
		.flush(redirect),
		.valid_in(fetch_valid),
		.data_in(if_payload),
		.valid_out(id_valid),
		.data_out(id_payload)
	);

	// ID stage
	register_file u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.we(wb_en),
		.waddr(wb_addr),
		.wdata(wb_value),
		.raddr_a(rf_raddr_a),
		.raddr_b(rf_raddr_b),
		.rdata_a(rf_rdata_a),
		.rdata_b(rf_rdata_b)
	);

	decoder u_decoder (
		.if_pc(id_payload.pc),
		.instr(id_payload.instr),
		.rdata_a(rf_rdata_a),
		.rdata_b(rf_rdata_b),
		.raddr_a(rf_raddr_a),
		.raddr_b(rf_raddr_b),
		.id_ex(id_ex_next)
	);

	pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
		.clk(clk),
		.rst_n(rst_n),
		.hold(hold),
		.flush(redirect),
		.valid_in(id_valid),
		.data_in(id_ex_next),
		.valid_out(ex_valid),
		.data_out(ex_payload)
	);

	// EXE stage
	execute_unit u_execute (
		.valid(ex_valid),
		.id_ex(ex_payload),
		.fwd_en(wb_en),
		.fwd_addr(wb_addr),
		.fwd_value(wb_value),
		.res_valid(res_valid),
		.res_we(res_we),
		.res_addr(res_addr),
		.res_value(res_value),
		.res_pc(res_pc),
		.res_illegal(res_illegal),
		.redirect(redirect),
		.redirect_pc(redirect_pc)
	);

	// WB stage
	writeback_stage u_writeback (
		.clk(clk),
		.rst_n(rst_n),
		.run(run),
		.res_valid(res_valid),
		.res_we(res_we),
		.res_addr(res_addr),
		.res_value(res_value),
		.res_pc(res_pc),
		.res_illegal(res_illegal),
		.retire(retire),
		.retire_pc(retire_pc),
		.wb_en(wb_en),
		.wb_addr(wb_addr),
		.wb_value(wb_value),
		.illegal(illegal)
	);

endmodule

//--- cpu16_pkg.sv
package cpu16_pkg;

	localparam int WORD_W = 16;
	localparam int REG_AW = 3;
	localparam int NUM_REGS = 8;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_AW-1:0] reg_addr_t;

	localparam word_t RESET_PC = 16'd0;

	// Instruction fields
	localparam int OP_HI = 15;
	localparam int OP_LO = 11;
	localparam int RX_HI = 10;
	localparam int RX_LO = 8;
	localparam int RY_HI = 7;
	localparam int RY_LO = 5;
	localparam int RZ_HI = 4;
	localparam int RZ_LO = 2;
	localparam int IMM8_HI = 7;
	localparam int IMM11_HI = 10;

	typedef enum logic [4:0] {
		OP_NOP   = 5'd0,
		OP_ADDU  = 5'd1,
		OP_SUBU  = 5'd2,
		OP_AND   = 5'd3,
		OP_OR    = 5'd4,
		OP_LI    = 5'd5,
		OP_ADDIU = 5'd6,
		OP_BEQZ  = 5'd7,
		OP_B     = 5'd8
	} op_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_PASS_B
	} alu_op_t;

	typedef enum logic [1:0] {
		BR_NONE,
		BR_BEQZ,
		BR_B
	} br_kind_t;

	typedef struct packed {
		word_t pc;
		word_t instr;
	} if_id_t;

	typedef struct packed {
		word_t     pc;
		word_t     instr;
		word_t     op_a;
		word_t     op_b;
		reg_addr_t src_a;
		reg_addr_t src_b;
		word_t     imm;
		logic      use_imm;
		alu_op_t   alu_op;
		logic      we;
		reg_addr_t rd;
		br_kind_t  br;
		logic      illegal;
	} id_ex_t;

endpackage

//--- decoder.sv
`timescale 1ns/100ps

module decoder import cpu16_pkg::*; (
	input  word_t     if_pc,
	input  word_t     instr,
	input  word_t     rdata_a,
	input  word_t     rdata_b,
	output reg_addr_t raddr_a,
	output reg_addr_t raddr_b,
	output id_ex_t    id_ex
);

	op_t       op;
	reg_addr_t rx;
	reg_addr_t ry;
	reg_addr_t rz;
	word_t     imm8_s;
	word_t     imm8_z;
	word_t     imm11_s;

	assign op = op_t'(instr[OP_HI:OP_LO]);
	assign rx = instr[RX_HI:RX_LO];
	assign ry = instr[RY_HI:RY_LO];
	assign rz = instr[RZ_HI:RZ_LO];

	assign imm8_s = {{(WORD_W-IMM8_HI-1){instr[IMM8_HI]}}, instr[IMM8_HI:0]};
	assign imm8_z = {{(WORD_W-IMM8_HI-1){1'b0}}, instr[IMM8_HI:0]};
	assign imm11_s = {{(WORD_W-IMM11_HI-1){instr[IMM11_HI]}}, instr[IMM11_HI:0]};

	always_comb begin
		raddr_a = '0;
		raddr_b = '0;
		id_ex = '0;
		id_ex.pc = if_pc;
		id_ex.instr = instr;
		id_ex.alu_op = ALU_ADD;
		id_ex.br = BR_NONE;
		case (op)
			OP_NOP: begin
			end
			OP_ADDU, OP_SUBU, OP_AND, OP_OR: begin
				raddr_a = rx;
				raddr_b = ry;
				id_ex.we = 1'b1;
				id_ex.rd = rz;
				case (op)
					OP_SUBU: id_ex.alu_op = ALU_SUB;
					OP_AND:  id_ex.alu_op = ALU_AND;
					OP_OR:   id_ex.alu_op = ALU_OR;
					default: id_ex.alu_op = ALU_ADD;
				endcase
			end
			OP_LI: begin
				id_ex.imm = imm8_z;
				id_ex.use_imm = 1'b1;
				id_ex.alu_op = ALU_PASS_B;
				id_ex.we = 1'b1;
				id_ex.rd = rx;
			end
			OP_ADDIU: begin
				raddr_a = rx;
				id_ex.imm = imm8_s;
				id_ex.use_imm = 1'b1;
				id_ex.we = 1'b1;
				id_ex.rd = rx;
			end
			OP_BEQZ: begin
				raddr_a = rx;
				id_ex.imm = imm8_s;
				id_ex.br = BR_BEQZ;
			end
			OP_B: begin
				id_ex.imm = imm11_s;
				id_ex.br = BR_B;
			end
			// Unknown opcode retires as a NOP
			default: id_ex.illegal = 1'b1;
		endcase
		id_ex.src_a = raddr_a;
		id_ex.src_b = raddr_b;
		id_ex.op_a = rdata_a;
		id_ex.op_b = rdata_b;
	end

	always_comb begin
		alu_op_known: assert (!$isunknown(id_ex.alu_op));
	end

endmodule

//--- execute_unit.sv
`timescale 1ns/100ps

module execute_unit import cpu16_pkg::*; (
	input  logic      valid,
	input  id_ex_t    id_ex,
	input  logic      fwd_en,
	input  reg_addr_t fwd_addr,
	input  word_t     fwd_value,
	output logic      res_valid,
	output logic      res_we,
	output reg_addr_t res_addr,
	output word_t     res_value,
	output word_t     res_pc,
	output logic      res_illegal,
	output logic      redirect,
	output word_t     redirect_pc
);

	word_t opnd_a;
	word_t opnd_b;
	word_t alu_b;
	logic  taken;

	always_comb begin
		// Bypass from the instruction now in writeback
		opnd_a = id_ex.op_a;
		opnd_b = id_ex.op_b;
		if (fwd_en && fwd_addr == id_ex.src_a) begin
			opnd_a = fwd_value;
		end
		if (fwd_en && fwd_addr == id_ex.src_b) begin
			opnd_b = fwd_value;
		end
		alu_b = id_ex.use_imm ? id_ex.imm : opnd_b;

		case (id_ex.alu_op)
			ALU_SUB:    res_value = opnd_a - alu_b;
			ALU_AND:    res_value = opnd_a & alu_b;
			ALU_OR:     res_value = opnd_a | alu_b;
			ALU_PASS_B: res_value = alu_b;
			default:    res_value = opnd_a + alu_b;
		endcase

		case (id_ex.br)
			BR_BEQZ: taken = (opnd_a == '0);
			BR_B:    taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign redirect = valid & taken;
	assign redirect_pc = id_ex.pc + word_t'(1) + id_ex.imm;

	assign res_valid = valid;
	assign res_we = id_ex.we;
	assign res_addr = id_ex.rd;
	assign res_pc = id_ex.pc;
	assign res_illegal = id_ex.illegal;

	always_comb begin
		redirect_from_branch: assert (!redirect || (valid && id_ex.br != BR_NONE));
	end

endmodule

//--- fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit import cpu16_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  run,
	input  logic  redirect,
	input  word_t redirect_pc,
	output word_t pc,
	output logic  fetch_valid
);

	// First cycle out of reset fetches nothing and pc stays at RESET_PC
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= RESET_PC;
			fetch_valid <= 1'b0;
		end else if (run) begin
			fetch_valid <= 1'b1;
			if (redirect) begin
				pc <= redirect_pc;
			end else if (fetch_valid) begin
				pc <= pc + word_t'(1);
			end
		end
	end

endmodule

//--- files.f
cpu16_pkg.sv
pipe_reg.sv
fetch_unit.sv
register_file.sv
decoder.sv
execute_unit.sv
writeback_stage.sv
cpu16_core.sv
tb_cpu16.sv

//--- pipe_reg.sv
`timescale 1ns/100ps

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     hold,
	input  logic     flush,
	input  logic     valid_in,
	input  payload_t data_in,
	output logic     valid_out,
	output payload_t data_out
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_out <= 1'b0;
		end else if (!hold) begin
			valid_out <= valid_in & ~flush;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			data_out <= data_in;
		end
	end

	// A squashed slot stays empty
	flush_empties_slot: assert property (@(posedge clk) disable iff (!rst_n)
		flush && !hold |=> !valid_out);

endmodule

//--- register_file.sv
`timescale 1ns/100ps

module register_file import cpu16_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      we,
	input  reg_addr_t waddr,
	input  word_t     wdata,
	input  reg_addr_t raddr_a,
	input  reg_addr_t raddr_b,
	output word_t     rdata_a,
	output word_t     rdata_b
);

	word_t regs [NUM_REGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// Write-through so decode sees the value retiring this cycle
	always_comb begin
		rdata_a = regs[raddr_a];
		rdata_b = regs[raddr_b];
		if (we && waddr == raddr_a) begin
			rdata_a = wdata;
		end
		if (we && waddr == raddr_b) begin
			rdata_b = wdata;
		end
	end

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --top-module tb_cpu16 -f files.f -o sim_cpu16 \
	> build.log 2>&1 \
	&& ./obj_dir/sim_cpu16 > sim.log 2>&1 \
	|| echo "compile or simulation ended with an error, see build.log and sim.log"
grep -q "^Done: no errors$" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

//--- tb_cpu16.sv
`timescale 1ns/100ps

module tb_cpu16 import cpu16_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int MEM_DEPTH = 256;
	localparam int HALT_PC = 200;
	localparam int DIRECTED_LEN = 40;
	localparam int RUN_LEN = 60;
	localparam int RAND_LEN = 200;
	localparam int TOTAL_LEN = 3 * DIRECTED_LEN + RUN_LEN + RAND_LEN;

	logic      clk;
	logic      rst_n;
	logic      run;
	word_t     imem_data;
	word_t     imem_addr;
	logic      retire;
	word_t     retire_pc;
	logic      wb_en;
	reg_addr_t wb_addr;
	word_t     wb_value;
	logic      illegal;

	word_t       imem [MEM_DEPTH];
	word_t       model_regs [NUM_REGS];
	word_t       model_pc;
	word_t       exp_pc;
	logic        exp_en;
	reg_addr_t   exp_addr;
	word_t       exp_value;
	logic        exp_illegal;
	int          retire_count;
	bit          halt_seen;
	bit          random_run_en;
	logic [31:0] rng_state = 32'h276657d7;

	cpu16_core u_cpu16_core (
		.clk(clk),
		.rst_n(rst_n),
		.run(run),
		.imem_data(imem_data),
		.imem_addr(imem_addr),
		.retire(retire),
		.retire_pc(retire_pc),
		.wb_en(wb_en),
		.wb_addr(wb_addr),
		.wb_value(wb_value),
		.illegal(illegal)
	);

	assign imem_data = imem[imem_addr[7:0]];

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic word_t enc_rrr(input logic [4:0] opc, input reg_addr_t rx,
			input reg_addr_t ry, input reg_addr_t rz);
		word_t w;
		w = '0;
		w[OP_HI:OP_LO] = opc;
		w[RX_HI:RX_LO] = rx;
		w[RY_HI:RY_LO] = ry;
		w[RZ_HI:RZ_LO] = rz;
		return w;
	endfunction

	function automatic word_t enc_ri(input logic [4:0] opc, input reg_addr_t rx,
			input logic [7:0] imm8);
		word_t w;
		w = '0;
		w[OP_HI:OP_LO] = opc;
		w[RX_HI:RX_LO] = rx;
		w[IMM8_HI:0] = imm8;
		return w;
	endfunction

	function automatic word_t enc_b(input logic [10:0] imm11);
		word_t w;
		w = '0;
		w[OP_HI:OP_LO] = OP_B;
		w[IMM11_HI:0] = imm11;
		return w;
	endfunction

	// Architectural model stepped once per retirement
	function automatic void ref_step();
		word_t      ins;
		logic [4:0] opc;
		reg_addr_t  rx;
		reg_addr_t  ry;
		reg_addr_t  rz;
		word_t      a;
		word_t      b;
		word_t      sx8;
		word_t      sx11;
		word_t      next_pc;
		ins = imem[model_pc[7:0]];
		opc = ins[OP_HI:OP_LO];
		rx = ins[RX_HI:RX_LO];
		ry = ins[RY_HI:RY_LO];
		rz = ins[RZ_HI:RZ_LO];
		a = model_regs[rx];
		b = model_regs[ry];
		sx8 = {{8{ins[7]}}, ins[7:0]};
		sx11 = {{5{ins[10]}}, ins[10:0]};
		exp_pc = model_pc;
		exp_en = 1'b0;
		exp_addr = '0;
		exp_value = '0;
		exp_illegal = 1'b0;
		next_pc = model_pc + word_t'(1);
		case (opc)
			OP_NOP: begin
			end
			OP_ADDU: begin
				exp_en = 1'b1;
				exp_addr = rz;
				exp_value = a + b;
			end
			OP_SUBU: begin
				exp_en = 1'b1;
				exp_addr = rz;
				exp_value = a - b;
			end
			OP_AND: begin
				exp_en = 1'b1;
				exp_addr = rz;
				exp_value = a & b;
			end
			OP_OR: begin
				exp_en = 1'b1;
				exp_addr = rz;
				exp_value = a | b;
			end
			OP_LI: begin
				exp_en = 1'b1;
				exp_addr = rx;
				exp_value = {8'h00, ins[7:0]};
			end
			OP_ADDIU: begin
				exp_en = 1'b1;
				exp_addr = rx;
				exp_value = a + sx8;
			end
			OP_BEQZ: begin
				if (a == 16'h0000) begin
					next_pc = model_pc + word_t'(1) + sx8;
				end
			end
			OP_B: next_pc = model_pc + word_t'(1) + sx11;
			default: exp_illegal = 1'b1;
		endcase
		if (exp_en) begin
			model_regs[exp_addr] = exp_value;
		end
		model_pc = next_pc;
	endfunction

	task automatic stop_with_failure();
		$display("Done: errors found");
		$fatal(1, "simulation stopped on the first failure");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got %h, expected %h at %0t", name, got, exp, $time);
			stop_with_failure();
		end
	endtask

	task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got %h, expected %h at %0t", name, got, exp, $time);
			stop_with_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got %h, expected %h at %0t", name, got, exp, $time);
			stop_with_failure();
		end
	endtask

	always @(negedge clk) begin : compare_retirements
		if (rst_n && !run) begin
			check_flag("retire", retire, 1'b0);
		end
		if (rst_n && retire) begin
			ref_step();
			check_word("retire_pc", retire_pc, exp_pc);
			check_flag("wb_en", wb_en, exp_en);
			check_flag("illegal", illegal, exp_illegal);
			if (exp_en) begin
				check_addr("wb_addr", wb_addr, exp_addr);
				check_word("wb_value", wb_value, exp_value);
			end
			retire_count++;
			if (exp_pc == word_t'(HALT_PC)) begin
				halt_seen = 1'b1;
			end
		end
	end

	initial begin : drive_run
		run = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			if (random_run_en) begin
				run = (next_rand() & 32'h3) != 32'h0;
			end else begin
				run = 1'b1;
			end
		end
	end

	initial begin : watchdog
		repeat (TOTAL_LEN * 20) @(posedge clk);
		$display("Timeout: a program did not reach its halt address in %0d cycles",
			TOTAL_LEN * 20);
		stop_with_failure();
	end

	// Every slot branches to HALT_PC and HALT_PC loops on itself
	task automatic clear_program();
		for (int a = 0; a < MEM_DEPTH; a++) begin
			imem[8'(a)] = enc_b(11'(HALT_PC - a - 1));
		end
	endtask

	function automatic word_t random_instr();
		logic [31:0] r;
		word_t       w;
		r = next_rand();
		case (r[3:0])
			4'd0: w = enc_rrr(OP_NOP, 3'd0, 3'd0, 3'd0);
			4'd3: w = enc_rrr(OP_SUBU, r[6:4], r[9:7], r[12:10]);
			4'd4: w = enc_rrr(OP_AND, r[6:4], r[9:7], r[12:10]);
			4'd5: w = enc_rrr(OP_OR, r[6:4], r[9:7], r[12:10]);
			4'd6, 4'd7, 4'd8: w = enc_ri(OP_LI, r[6:4], r[23:16]);
			4'd9, 4'd10: w = enc_ri(OP_ADDIU, r[6:4], r[23:16]);
			// Forward branches only so that every program reaches HALT_PC
			4'd11, 4'd12: w = enc_ri(OP_BEQZ, r[6:4], 8'(r[18:16] % 3'd6));
			4'd13: w = enc_b(11'(r[18:16] % 3'd6));
			4'd14: begin
				w = r[31:16];
				w[OP_HI:OP_LO] = 5'd9 + 5'(r[28:24] % 5'd23);
			end
			default: w = enc_rrr(OP_ADDU, r[6:4], r[9:7], r[12:10]);
		endcase
		return w;
	endfunction

	task automatic load_random_program(input int len);
		for (int i = 0; i < len; i++) begin
			imem[8'(i)] = random_instr();
		end
	endtask

	task automatic load_alu_program();
		imem[0] = enc_ri(OP_LI, 3'd1, 8'h35);
		imem[1] = enc_ri(OP_LI, 3'd2, 8'h0f);
		imem[2] = enc_rrr(OP_ADDU, 3'd1, 3'd2, 3'd3);
		imem[3] = enc_rrr(OP_SUBU, 3'd3, 3'd1, 3'd4);
		imem[4] = enc_rrr(OP_AND, 3'd4, 3'd3, 3'd5);
		imem[5] = enc_rrr(OP_OR, 3'd5, 3'd2, 3'd6);
		imem[6] = enc_ri(OP_ADDIU, 3'd6, 8'hfd);
		imem[7] = enc_ri(OP_ADDIU, 3'd6, 8'h7f);
		imem[8] = enc_rrr(OP_SUBU, 3'd0, 3'd6, 3'd7);
		imem[9] = enc_rrr(OP_ADDU, 3'd7, 3'd7, 3'd7);
		imem[10] = enc_ri(OP_LI, 3'd0, 8'hff);
		imem[11] = enc_rrr(OP_AND, 3'd0, 3'd7, 3'd1);
		imem[12] = enc_rrr(OP_OR, 3'd1, 3'd1, 3'd2);
		imem[13] = enc_ri(OP_ADDIU, 3'd2, 8'h80);
	endtask

	task automatic load_branch_program();
		imem[0] = enc_ri(OP_LI, 3'd1, 8'h00);
		imem[1] = enc_ri(OP_LI, 3'd2, 8'h05);
		imem[2] = enc_ri(OP_BEQZ, 3'd1, 8'h03);
		imem[3] = enc_ri(OP_LI, 3'd3, 8'h11);
		imem[4] = enc_ri(OP_LI, 3'd3, 8'h22);
		imem[5] = enc_ri(OP_LI, 3'd3, 8'h33);
		imem[6] = enc_ri(OP_BEQZ, 3'd2, 8'h02);
		// Count r2 down to zero
		imem[7] = enc_ri(OP_ADDIU, 3'd2, 8'hff);
		imem[8] = enc_ri(OP_BEQZ, 3'd2, 8'h01);
		imem[9] = enc_b(11'h7fd);
		imem[10] = enc_ri(OP_LI, 3'd4, 8'h44);
		imem[11] = enc_b(11'h002);
		imem[12] = enc_ri(OP_LI, 3'd4, 8'h55);
		imem[13] = enc_ri(OP_LI, 3'd4, 8'h66);
		imem[14] = enc_rrr(OP_ADDU, 3'd4, 3'd2, 3'd5);
	endtask

	task automatic load_illegal_program();
		imem[0] = enc_ri(OP_LI, 3'd1, 8'h12);
		imem[1] = enc_ri(OP_LI, 3'd2, 8'h34);
		imem[2] = enc_rrr(5'd9, 3'd1, 3'd2, 3'd3);
		imem[3] = 16'hffff;
		imem[4] = enc_rrr(OP_ADDU, 3'd1, 3'd2, 3'd3);
		imem[5] = enc_ri(5'd16, 3'd3, 8'ha5);
		imem[6] = enc_rrr(OP_OR, 3'd3, 3'd1, 3'd1);
		imem[7] = enc_rrr(OP_ADDU, 3'd1, 3'd3, 3'd6);
	endtask

	task automatic begin_reset(input bit random_run);
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		@(negedge clk);
		random_run_en = random_run;
		model_pc = RESET_PC;
		for (int i = 0; i < NUM_REGS; i++) begin
			model_regs[3'(i)] = '0;
		end
		retire_count = 0;
		halt_seen = 1'b0;
		check_word("imem_addr", imem_addr, RESET_PC);
		check_flag("retire", retire, 1'b0);
		check_flag("wb_en", wb_en, 1'b0);
		check_flag("illegal", illegal, 1'b0);
		clear_program();
	endtask

	task automatic end_reset();
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
	endtask

	task automatic wait_for_halt(input string name);
		while (!halt_seen) begin
			@(posedge clk);
		end
		$display("%s: %0d instructions retired", name, retire_count);
	endtask

	initial begin
		rst_n = 1'b0;
		random_run_en = 1'b0;
		clear_program();

		begin_reset(1'b0);
		load_alu_program();
		end_reset();
		wait_for_halt("dependent ALU program");

		begin_reset(1'b0);
		load_branch_program();
		end_reset();
		wait_for_halt("branch program");

		begin_reset(1'b0);
		load_illegal_program();
		end_reset();
		wait_for_halt("illegal opcode program");

		begin_reset(1'b1);
		load_random_program(RUN_LEN);
		end_reset();
		wait_for_halt("random program with run pulses");

		begin_reset(1'b0);
		load_random_program(RAND_LEN);
		end_reset();
		wait_for_halt("random program");

		$display("Done: no errors");
		$finish;
	end

endmodule

//--- writeback_stage.sv
`timescale 1ns/100ps

module writeback_stage import cpu16_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      run,
	input  logic      res_valid,
	input  logic      res_we,
	input  reg_addr_t res_addr,
	input  word_t     res_value,
	input  word_t     res_pc,
	input  logic      res_illegal,
	output logic      retire,
	output word_t     retire_pc,
	output logic      wb_en,
	output reg_addr_t wb_addr,
	output word_t     wb_value,
	output logic      illegal
);

	logic valid_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
			wb_en <= 1'b0;
			illegal <= 1'b0;
		end else if (run) begin
			valid_q <= res_valid;
			wb_en <= res_valid & res_we & ~res_illegal;
			illegal <= res_valid & res_illegal;
		end
	end

	always_ff @(posedge clk) begin
		if (run) begin
			retire_pc <= res_pc;
			wb_addr <= res_addr;
			wb_value <= res_value;
		end
	end

	// Counted in the cycle before the entry is replaced
	assign retire = valid_q & run;

endmodule
